/* periph_soc.f */
src/periph_pkg.sv
src/periph_router.sv
src/device_table.sv
src/gpio_port.sv
src/int_ctrl.sv
src/reset_seq.sv
src/periph_soc.sv
verif/periph_soc_properties.sv
verif/periph_soc_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= periph_soc_tb
FILELIST  ?= periph_soc.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/periph_soc_tb.sv */
`timescale 1ns/1ps

module periph_soc_tb;

	localparam int MAX_ROWS       = 40;
	localparam int CYCLES_PER_ROW = 16;
	localparam int TIMEOUT_CYCLES = MAX_ROWS * CYCLES_PER_ROW + 200;
	localparam int WARM_WAIT      = periph_pkg::RESET_HOLD_CYCLES + 2;
	localparam periph_pkg::bus_op_t RD = periph_pkg::OP_READ;
	localparam periph_pkg::bus_op_t WR = periph_pkg::OP_WRITE;

	logic                              clk_2x_w;
	logic                              rst_p;
	logic                              req_valid_i;
	logic                              req_ready_o;
	periph_pkg::bus_op_t               req_op_i;
	logic [periph_pkg::ADDR_W-1:0]     req_addr_i;
	logic [periph_pkg::DATA_W-1:0]     req_wdata_i;
	logic                              rsp_valid_o;
	logic                              rsp_ready_i;
	logic [periph_pkg::DATA_W-1:0]     rsp_rdata_o;
	logic [periph_pkg::GP0_COUNT-1:0]  gp0_i;
	logic [periph_pkg::GP0_COUNT-1:0]  gp0_o;
	logic [periph_pkg::GP1_COUNT-1:0]  gp1_i;
	logic                              irq_o;

	// A value of -1 in an expectation column means not checked
	string                             row_name    [MAX_ROWS];
	periph_pkg::bus_op_t               row_op      [MAX_ROWS];
	logic [periph_pkg::ADDR_W-1:0]     row_addr    [MAX_ROWS];
	logic [periph_pkg::DATA_W-1:0]     row_wdata   [MAX_ROWS];
	logic [periph_pkg::GP0_COUNT-1:0]  row_gp0     [MAX_ROWS];
	logic [periph_pkg::GP1_COUNT-1:0]  row_gp1     [MAX_ROWS];
	int                                row_idle    [MAX_ROWS];
	int                                row_irq     [MAX_ROWS];
	logic [periph_pkg::DATA_W-1:0]     row_exp     [MAX_ROWS];
	int                                row_gp0_exp [MAX_ROWS];

	int n_rows;
	int checks;
	int errors;
	int cycles;

	periph_soc dut (.*);

	task automatic add_row(input string name, input periph_pkg::bus_op_t op,
			input logic [periph_pkg::ADDR_W-1:0] addr, input logic [31:0] wdata,
			input logic [15:0] gp0, input logic [4:0] gp1, input int idle,
			input int irq_exp, input logic [31:0] rdata_exp, input int gp0_exp);
		row_name[n_rows]    = name;
		row_op[n_rows]      = op;
		row_addr[n_rows]    = addr;
		row_wdata[n_rows]   = wdata;
		row_gp0[n_rows]     = gp0;
		row_gp1[n_rows]     = gp1;
		row_idle[n_rows]    = idle;
		row_irq[n_rows]     = irq_exp;
		row_exp[n_rows]     = rdata_exp;
		row_gp0_exp[n_rows] = gp0_exp;
		n_rows++;
	endtask

	task automatic check_value(input string name, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s %s: expected 0x%08h, actual 0x%08h",
				name, what, expected, actual);
		end
	endtask

	task automatic run_row(input int i);
		int          delay;
		int          lat;
		logic [31:0] held;
		gp0_i = row_gp0[i];
		gp1_i = row_gp1[i];
		repeat (row_idle[i]) @(negedge clk_2x_w);
		if (row_irq[i] >= 0)
			check_value(row_name[i], "irq_o", 32'(row_irq[i]), {31'b0, irq_o});
		req_valid_i = 1'b1;
		req_op_i    = row_op[i];
		req_addr_i  = row_addr[i];
		req_wdata_i = row_wdata[i];
		while (!req_ready_o) @(negedge clk_2x_w);
		@(negedge clk_2x_w);
		req_valid_i = 1'b0;
		lat = 0;
		while (!rsp_valid_o) begin
			checks++;
			if (req_ready_o) begin
				errors++;
				$display("%s: request side ready again before the response", row_name[i]);
			end
			@(negedge clk_2x_w);
			lat++;
		end
		check_value(row_name[i], "latency", 32'd2, 32'(lat));
		check_value(row_name[i], "rdata", row_exp[i], rsp_rdata_o);
		held  = rsp_rdata_o;
		delay = $urandom % 8;
		// Back-pressure on the response side
		repeat (delay) begin
			@(negedge clk_2x_w);
			checks++;
			if (!rsp_valid_o || rsp_rdata_o !== held || req_ready_o) begin
				errors++;
				$display("%s: response not held while the master stalled", row_name[i]);
			end
		end
		rsp_ready_i = 1'b1;
		@(negedge clk_2x_w);
		rsp_ready_i = 1'b0;
		checks++;
		if (!req_ready_o || rsp_valid_o) begin
			errors++;
			$display("%s: handshake did not complete when the response was taken", row_name[i]);
		end
		if (row_gp0_exp[i] >= 0)
			check_value(row_name[i], "gp0_o", 32'(row_gp0_exp[i]), 32'(gp0_o));
	endtask

	task automatic fill_table();
		// name, op, addr, wdata, gp0, gp1, idle, irq, rdata, gp0_o
		add_row("dt_count", RD, 'h000, 0, 'h0, 'h0, 0, -1, 'h4, -1);
		add_row("dt_past_end", RD, 'h009, 0, 'h0, 'h0, 0, -1, 'h0, -1);
		add_row("dt_dev0_id", RD, 'h001, 0, 'h0, 'h0, 0, -1, 'h0000_0007, -1);
		add_row("dt_dev0_size", RD, 'h002, 0, 'h0, 'h0, 0, -1, 'h10, -1);
		add_row("dt_dev1_id", RD, 'h003, 0, 'h0, 'h0, 0, -1, 'h8000_0006, -1);
		add_row("dt_dev1_size", RD, 'h004, 0, 'h0, 'h0, 0, -1, 'h4, -1);
		add_row("dt_dev2_id", RD, 'h005, 0, 'h0, 'h0, 0, -1, 'h8000_0006, -1);
		add_row("dt_dev2_size", RD, 'h006, 0, 'h0, 'h0, 0, -1, 'h4, -1);
		add_row("dt_dev3_id", RD, 'h007, 0, 'h0, 'h0, 0, -1, 'h0000_0003, -1);
		add_row("dt_dev3_size", RD, 'h008, 0, 'h0, 'h0, 0, -1, 'h4, -1);
		add_row("gp0_out_wr", WR, 'h011, 'hA5C3, 'h0, 'h0, 0, -1, 'h0, 'hA5C3);
		add_row("gp0_out_rd", RD, 'h011, 0, 'h0, 'h0, 0, -1, 'hA5C3, 'hA5C3);
		add_row("gp0_in_rd", RD, 'h010, 0, 'h1234, 'h0, 3, -1, 'h1234, -1);
		add_row("gp1_in_rd", RD, 'h014, 0, 'h1234, 'h0B, 3, -1, 'h0B, -1);
		add_row("gp1_mask_wr", WR, 'h016, 'h1F, 'h1234, 'h0B, 0, -1, 'h0, -1);
		add_row("gp1_mask_rd", RD, 'h016, 0, 'h1234, 'h0B, 0, 0, 'h1F, -1);
		// Pin change must reach irq_o within four cycles
		add_row("gp1_change_irq", RD, 'h018, 0, 'h1234, 'h0A, 4, 1, 'h1, -1);
		add_row("ic_empty", RD, 'h018, 0, 'h1234, 'h0A, 0, 0, 'hFFFF_FFFF, -1);
		add_row("unmapped_rd", RD, 'h01C, 0, 'h1234, 'h0A, 0, -1, 'h0, -1);
		add_row("unmapped_rd_top", RD, 'hFFF, 0, 'h1234, 'h0A, 0, -1, 'h0, -1);
		add_row("unmapped_wr", WR, 'h020, 'hFFFF_FFFF, 'h1234, 'h0A, 0, -1, 'h0, 'hA5C3);
		add_row("gp0_out_unmap", RD, 'h011, 0, 'h1234, 'h0A, 0, -1, 'hA5C3, 'hA5C3);
		add_row("gp1_mask_unmap", RD, 'h016, 0, 'h1234, 'h0A, 0, -1, 'h1F, -1);
		add_row("warm_reset_wr", WR, 'h000, 'h1, 'h1234, 'h0A, 0, -1, 'h0, -1);
		add_row("gp0_out_warm", RD, 'h011, 0, 'h1234, 'h0A, WARM_WAIT, 0, 'h0, 'h0);
		add_row("gp1_mask_warm", RD, 'h016, 0, 'h1234, 'h0A, 0, -1, 'h0, -1);
		add_row("dt_count_warm", RD, 'h000, 0, 'h1234, 'h0A, 0, -1, 'h4, -1);
		add_row("dt_dev1_id_warm", RD, 'h003, 0, 'h1234, 'h0A, 0, -1, 'h8000_0006, -1);
		add_row("ic_empty_warm", RD, 'h018, 0, 'h1234, 'h0A, 0, 0, 'hFFFF_FFFF, -1);
	endtask

	initial begin
		clk_2x_w = 1'b0;
		forever #5 clk_2x_w = ~clk_2x_w;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) @(posedge clk_2x_w) cycles++;
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Verification failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h16516da9));
		rst_p       = 1'b1;
		req_valid_i = 1'b0;
		req_op_i    = periph_pkg::OP_READ;
		req_addr_i  = '0;
		req_wdata_i = '0;
		rsp_ready_i = 1'b0;
		gp0_i       = '0;
		gp1_i       = '0;
		n_rows      = 0;
		checks      = 0;
		errors      = 0;
		fill_table();
		repeat (8) @(negedge clk_2x_w);
		rst_p = 1'b0;
		check_value("reset", "req_ready_o", 32'd1, {31'b0, req_ready_o});
		check_value("reset", "rsp_valid_o", 32'd0, {31'b0, rsp_valid_o});
		repeat (periph_pkg::RESET_HOLD_CYCLES) @(negedge clk_2x_w);
		check_value("reset", "irq_o", 32'd0, {31'b0, irq_o});
		check_value("reset", "gp0_o", 32'd0, 32'(gp0_o));
		for (int i = 0; i < n_rows; i++)
			run_row(i);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* verif/periph_soc_properties.sv */
`timescale 1ns/1ps

module periph_soc_properties (
	input logic                          clk_2x_w,
	input logic                          rst_p,
	input logic                          req_ready_i,
	input logic                          rsp_valid_i,
	input logic                          rsp_ready_i,
	input logic [periph_pkg::DATA_W-1:0] rsp_rdata_i,
	input logic                          periph_rst_i,
	input logic                          irq_i
);

	// Stalled response keeps its valid and data
	assert property (@(posedge clk_2x_w) disable iff (rst_p)
		rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_rdata_i))
		else $error("response changed while the master stalled");

	// One transaction in flight
	assert property (@(posedge clk_2x_w) disable iff (rst_p)
		rsp_valid_i |-> !req_ready_i)
		else $error("request side ready while a response is pending");

	// Pending bits clear on the first edge of the peripheral reset
	assert property (@(posedge clk_2x_w) disable iff (rst_p)
		periph_rst_i && $past(periph_rst_i) |-> !irq_i)
		else $error("interrupt raised during peripheral reset");

endmodule

bind periph_soc periph_soc_properties props (
	.clk_2x_w     (clk_2x_w),
	.rst_p        (rst_p),
	.req_ready_i  (req_ready_o),
	.rsp_valid_i  (rsp_valid_o),
	.rsp_ready_i  (rsp_ready_i),
	.rsp_rdata_i  (rsp_rdata_o),
	.periph_rst_i (periph_rst),
	.irq_i        (irq_o)
);

/* src/periph_soc.sv */
`timescale 1ns/1ps

module periph_soc (
	input  logic                              clk_2x_w,
	input  logic                              rst_p,
	input  logic                              req_valid_i,
	output logic                              req_ready_o,
	input  periph_pkg::bus_op_t               req_op_i,
	input  logic [periph_pkg::ADDR_W-1:0]     req_addr_i,
	input  logic [periph_pkg::DATA_W-1:0]     req_wdata_i,
	output logic                              rsp_valid_o,
	input  logic                              rsp_ready_i,
	output logic [periph_pkg::DATA_W-1:0]     rsp_rdata_o,
	input  logic [periph_pkg::GP0_COUNT-1:0]  gp0_i,
	output logic [periph_pkg::GP0_COUNT-1:0]  gp0_o,
	input  logic [periph_pkg::GP1_COUNT-1:0]  gp1_i,
	output logic                              irq_o
);

	logic [periph_pkg::SLAVE_COUNT-1:0]   sel;
	periph_pkg::bus_op_t                  op;
	logic [periph_pkg::ADDR_W-1:0]        offset;
	logic [periph_pkg::DATA_W-1:0]        wdata;
	logic [periph_pkg::DATA_W-1:0]        devtbl_rdata;
	logic [periph_pkg::DATA_W-1:0]        gpio0_rdata;
	logic [periph_pkg::DATA_W-1:0]        gpio1_rdata;
	logic [periph_pkg::DATA_W-1:0]        intctrl_rdata;
	logic [periph_pkg::INT_SRC_COUNT-1:0] src_intr;
	logic                                 warm_rst_req;
	logic                                 periph_rst;

	periph_router router (
		.clk_2x_w        (clk_2x_w),
		.rst_p           (rst_p),
		.req_valid_i     (req_valid_i),
		.req_ready_o     (req_ready_o),
		.req_op_i        (req_op_i),
		.req_addr_i      (req_addr_i),
		.req_wdata_i     (req_wdata_i),
		.rsp_valid_o     (rsp_valid_o),
		.rsp_ready_i     (rsp_ready_i),
		.rsp_rdata_o     (rsp_rdata_o),
		.sel_o           (sel),
		.op_o            (op),
		.offset_o        (offset),
		.wdata_o         (wdata),
		.devtbl_rdata_i  (devtbl_rdata),
		.gpio0_rdata_i   (gpio0_rdata),
		.gpio1_rdata_i   (gpio1_rdata),
		.intctrl_rdata_i (intctrl_rdata)
	);

	device_table devtbl (
		.clk_2x_w       (clk_2x_w),
		.rst_p          (rst_p),
		.sel_i          (sel[periph_pkg::SLV_DEVTBL]),
		.op_i           (op),
		.offset_i       (offset),
		.wdata_i        (wdata),
		.rdata_o        (devtbl_rdata),
		.warm_rst_req_o (warm_rst_req)
	);

	// Switches and LEDs
	gpio_port #(.IO_COUNT(periph_pkg::GP0_COUNT)) gpio0 (
		.clk_2x_w     (clk_2x_w),
		.periph_rst_i (periph_rst),
		.sel_i        (sel[periph_pkg::SLV_GPIO0]),
		.op_i         (op),
		.offset_i     (offset),
		.wdata_i      (wdata),
		.rdata_o      (gpio0_rdata),
		.pins_i       (gp0_i),
		.pins_o       (gp0_o),
		.intr_o       (src_intr[periph_pkg::INT_SRC_GP0])
	);

	// Buttons, input only
	gpio_port #(.IO_COUNT(periph_pkg::GP1_COUNT)) gpio1 (
		.clk_2x_w     (clk_2x_w),
		.periph_rst_i (periph_rst),
		.sel_i        (sel[periph_pkg::SLV_GPIO1]),
		.op_i         (op),
		.offset_i     (offset),
		.wdata_i      (wdata),
		.rdata_o      (gpio1_rdata),
		.pins_i       (gp1_i),
		.pins_o       (),
		.intr_o       (src_intr[periph_pkg::INT_SRC_GP1])
	);

	int_ctrl intctrl (
		.clk_2x_w     (clk_2x_w),
		.periph_rst_i (periph_rst),
		.sel_i        (sel[periph_pkg::SLV_INTCTRL]),
		.op_i         (op),
		.offset_i     (offset),
		.rdata_o      (intctrl_rdata),
		.src_intr_i   (src_intr),
		.irq_o        (irq_o)
	);

	reset_seq rstseq (
		.clk_2x_w       (clk_2x_w),
		.rst_p          (rst_p),
		.warm_rst_req_i (warm_rst_req),
		.periph_rst_o   (periph_rst)
	);

endmodule

/* src/reset_seq.sv */
`timescale 1ns/1ps

module reset_seq (
	input  logic clk_2x_w,
	input  logic rst_p,
	input  logic warm_rst_req_i,
	output logic periph_rst_o
);

	logic [periph_pkg::RESET_CNT_W-1:0] cnt_q;

	// Reloads while board reset is held, then counts down to release
	always_ff @(posedge clk_2x_w) begin
		if (rst_p || warm_rst_req_i)
			cnt_q <= periph_pkg::RESET_LOAD;
		else if (cnt_q != '0)
			cnt_q <= cnt_q - 1'b1;
	end

	assign periph_rst_o = (cnt_q != '0);

endmodule

/* src/int_ctrl.sv */
`timescale 1ns/1ps

module int_ctrl (
	input  logic                                  clk_2x_w,
	input  logic                                  periph_rst_i,
	input  logic                                  sel_i,
	input  periph_pkg::bus_op_t                   op_i,
	input  logic [periph_pkg::ADDR_W-1:0]         offset_i,
	output logic [periph_pkg::DATA_W-1:0]         rdata_o,
	input  logic [periph_pkg::INT_SRC_COUNT-1:0]  src_intr_i,
	output logic                                  irq_o
);

	logic [periph_pkg::INT_SRC_COUNT-1:0] pending_q;
	logic [periph_pkg::INT_SRC_COUNT-1:0] clr;
	logic [periph_pkg::DATA_W-1:0]        lowest;
	logic                                 claim;

	assign claim = sel_i && op_i == periph_pkg::OP_READ && offset_i == '0;
	assign irq_o = |pending_q;

	// Lowest pending index wins, scanned from the top down
	always_comb begin
		lowest = periph_pkg::INT_NONE;
		clr    = '0;
		for (int i = periph_pkg::INT_SRC_COUNT - 1; i >= 0; i--) begin
			if (pending_q[i]) begin
				lowest = i;
				clr    = '0;
				clr[i] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (periph_rst_i) begin
			pending_q <= '0;
		end else if (claim) begin
			// A new pulse on the claimed source stays pending
			pending_q <= (pending_q & ~clr) | src_intr_i;
		end else begin
			pending_q <= pending_q | src_intr_i;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sel_i)
			rdata_o <= (offset_i == '0) ? lowest : '0;
	end

endmodule

/* src/gpio_port.sv */
`timescale 1ns/1ps

module gpio_port #(
	parameter int IO_COUNT = 16
) (
	input  logic                           clk_2x_w,
	input  logic                           periph_rst_i,
	input  logic                           sel_i,
	input  periph_pkg::bus_op_t            op_i,
	input  logic [periph_pkg::ADDR_W-1:0]  offset_i,
	input  logic [periph_pkg::DATA_W-1:0]  wdata_i,
	output logic [periph_pkg::DATA_W-1:0]  rdata_o,
	input  logic [IO_COUNT-1:0]            pins_i,
	output logic [IO_COUNT-1:0]            pins_o,
	output logic                           intr_o
);

	logic [IO_COUNT-1:0]           sync1_q;
	logic [IO_COUNT-1:0]           sync2_q;
	logic [IO_COUNT-1:0]           prev_q;
	logic [IO_COUNT-1:0]           out_q;
	logic [IO_COUNT-1:0]           mask_q;
	logic [IO_COUNT-1:0]           change;
	logic [periph_pkg::DATA_W-1:0] word;

	// Two-stage input synchronizer and previous sample
	always_ff @(posedge clk_2x_w) begin
		sync1_q <= pins_i;
		sync2_q <= sync1_q;
		prev_q  <= sync2_q;
	end

	assign change = (sync2_q ^ prev_q) & mask_q;
	assign pins_o = out_q;

	always_ff @(posedge clk_2x_w) begin
		if (periph_rst_i) begin
			out_q  <= '0;
			mask_q <= '0;
			intr_o <= 1'b0;
		end else begin
			intr_o <= |change;
			if (sel_i && op_i == periph_pkg::OP_WRITE) begin
				if (offset_i == 1)
					out_q <= wdata_i[IO_COUNT-1:0];
				else if (offset_i == 2)
					mask_q <= wdata_i[IO_COUNT-1:0];
			end
		end
	end

	always_comb begin
		word = '0;
		case (offset_i)
			0:       word[IO_COUNT-1:0] = sync2_q;
			1:       word[IO_COUNT-1:0] = out_q;
			2:       word[IO_COUNT-1:0] = mask_q;
			default: word = '0;
		endcase
	end

	always_ff @(posedge clk_2x_w) begin
		if (sel_i)
			rdata_o <= word;
	end

endmodule

/* src/device_table.sv */
`timescale 1ns/1ps

module device_table (
	input  logic                           clk_2x_w,
	input  logic                           rst_p,
	input  logic                           sel_i,
	input  periph_pkg::bus_op_t            op_i,
	input  logic [periph_pkg::ADDR_W-1:0]  offset_i,
	input  logic [periph_pkg::DATA_W-1:0]  wdata_i,
	output logic [periph_pkg::DATA_W-1:0]  rdata_o,
	output logic                           warm_rst_req_o
);

	logic [periph_pkg::ADDR_W-1:0] ent;
	periph_pkg::slave_t            slv;
	logic [periph_pkg::DATA_W-1:0] word;

	// Two words per device after the count word
	assign ent = (offset_i - 1'b1) >> 1;
	assign slv = periph_pkg::slave_t'(ent[$bits(periph_pkg::slave_t)-1:0]);

	always_comb begin
		word = '0;
		if (offset_i == '0) begin
			word = periph_pkg::SLAVE_COUNT;
		end else if (ent < periph_pkg::SLAVE_COUNT) begin
			if (offset_i[0]) begin
				// Odd word: interrupt use and device id
				word[periph_pkg::DATA_W-1] = periph_pkg::DEV_USEINTR[slv];
				word[15:0]                 = periph_pkg::DEV_ID[slv];
			end else begin
				word[periph_pkg::ADDR_W-1:0] = periph_pkg::DEV_MAPSZ[slv];
			end
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sel_i)
			rdata_o <= word;
	end

	// Software warm reset through bit 0 of word 0
	always_ff @(posedge clk_2x_w) begin
		if (rst_p)
			warm_rst_req_o <= 1'b0;
		else
			warm_rst_req_o <= sel_i && op_i == periph_pkg::OP_WRITE &&
				offset_i == '0 && wdata_i[0];
	end

endmodule

/* src/periph_router.sv */
`timescale 1ns/1ps

module periph_router (
	input  logic                                clk_2x_w,
	input  logic                                rst_p,
	input  logic                                req_valid_i,
	output logic                                req_ready_o,
	input  periph_pkg::bus_op_t                 req_op_i,
	input  logic [periph_pkg::ADDR_W-1:0]       req_addr_i,
	input  logic [periph_pkg::DATA_W-1:0]       req_wdata_i,
	output logic                                rsp_valid_o,
	input  logic                                rsp_ready_i,
	output logic [periph_pkg::DATA_W-1:0]       rsp_rdata_o,
	output logic [periph_pkg::SLAVE_COUNT-1:0]  sel_o,
	output periph_pkg::bus_op_t                 op_o,
	output logic [periph_pkg::ADDR_W-1:0]       offset_o,
	output logic [periph_pkg::DATA_W-1:0]       wdata_o,
	input  logic [periph_pkg::DATA_W-1:0]       devtbl_rdata_i,
	input  logic [periph_pkg::DATA_W-1:0]       gpio0_rdata_i,
	input  logic [periph_pkg::DATA_W-1:0]       gpio1_rdata_i,
	input  logic [periph_pkg::DATA_W-1:0]       intctrl_rdata_i
);

	typedef enum logic [1:0] {IDLE, WAIT, RESP} state_t;

	state_t                               state_q;
	logic                                 strobe_q;
	logic                                 accept;
	logic                                 hit_d;
	logic                                 hit_q;
	periph_pkg::slave_t                   slv_d;
	periph_pkg::slave_t                   slv_q;
	logic [periph_pkg::ADDR_W-1:0]        base_d;
	logic [periph_pkg::SLAVE_COUNT-1:0]   sel_d;
	logic [periph_pkg::DATA_W-1:0]        slave_rdata;

	// Below-base addresses wrap to large values and fall outside
	function automatic logic in_window(input logic [periph_pkg::ADDR_W-1:0] addr,
			input logic [periph_pkg::ADDR_W-1:0] base,
			input logic [periph_pkg::ADDR_W-1:0] size);
		logic [periph_pkg::ADDR_W-1:0] rel;
		rel = addr - base;
		return rel < size;
	endfunction

	assign req_ready_o = (state_q == IDLE);
	assign rsp_valid_o = (state_q == RESP);
	assign accept      = req_valid_i && req_ready_o;

	always_comb begin
		hit_d  = 1'b1;
		slv_d  = periph_pkg::SLV_DEVTBL;
		base_d = periph_pkg::DEVTBL_BASE;
		if (in_window(req_addr_i, periph_pkg::DEVTBL_BASE, periph_pkg::DEVTBL_SIZE)) begin
			slv_d  = periph_pkg::SLV_DEVTBL;
			base_d = periph_pkg::DEVTBL_BASE;
		end else if (in_window(req_addr_i, periph_pkg::GPIO0_BASE, periph_pkg::GPIO0_SIZE)) begin
			slv_d  = periph_pkg::SLV_GPIO0;
			base_d = periph_pkg::GPIO0_BASE;
		end else if (in_window(req_addr_i, periph_pkg::GPIO1_BASE, periph_pkg::GPIO1_SIZE)) begin
			slv_d  = periph_pkg::SLV_GPIO1;
			base_d = periph_pkg::GPIO1_BASE;
		end else if (in_window(req_addr_i, periph_pkg::INTCTRL_BASE,
				periph_pkg::INTCTRL_SIZE)) begin
			slv_d  = periph_pkg::SLV_INTCTRL;
			base_d = periph_pkg::INTCTRL_BASE;
		end else begin
			// Default slave: nothing strobed, zero reply
			hit_d = 1'b0;
		end
		sel_d = '0;
		if (hit_d)
			sel_d[slv_d] = 1'b1;
	end

	always_comb begin
		case (slv_q)
			periph_pkg::SLV_GPIO0:   slave_rdata = gpio0_rdata_i;
			periph_pkg::SLV_GPIO1:   slave_rdata = gpio1_rdata_i;
			periph_pkg::SLV_INTCTRL: slave_rdata = intctrl_rdata_i;
			default:                 slave_rdata = devtbl_rdata_i;
		endcase
	end

	// Strobe cycle, then slave reply cycle, then hold until taken
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			state_q  <= IDLE;
			strobe_q <= 1'b0;
			sel_o    <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (accept) begin
						state_q  <= WAIT;
						strobe_q <= 1'b1;
						sel_o    <= sel_d;
					end
				end
				WAIT: begin
					if (strobe_q) begin
						strobe_q <= 1'b0;
						sel_o    <= '0;
					end else begin
						state_q <= RESP;
					end
				end
				RESP: begin
					if (rsp_ready_i)
						state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (accept) begin
			op_o     <= req_op_i;
			offset_o <= req_addr_i - base_d;
			wdata_o  <= req_wdata_i;
			hit_q    <= hit_d;
			slv_q    <= slv_d;
		end
		// Writes and unmapped accesses answer with zero
		if (state_q == WAIT && !strobe_q)
			rsp_rdata_o <= (hit_q && op_o == periph_pkg::OP_READ) ? slave_rdata : '0;
	end

endmodule

/* src/periph_pkg.sv */
package periph_pkg;

	// Bus geometry
	localparam int DATA_W = 32;
	localparam int ADDR_W = 12;

	typedef enum logic {OP_READ, OP_WRITE} bus_op_t;

	typedef enum logic [1:0] {
		SLV_DEVTBL,
		SLV_GPIO0,
		SLV_GPIO1,
		SLV_INTCTRL
	} slave_t;

	localparam int SLAVE_COUNT = 4;

	// Word address map, sizes in words
	localparam logic [ADDR_W-1:0] DEVTBL_BASE  = 12'h000;
	localparam logic [ADDR_W-1:0] DEVTBL_SIZE  = 12'h010;
	localparam logic [ADDR_W-1:0] GPIO0_BASE   = 12'h010;
	localparam logic [ADDR_W-1:0] GPIO0_SIZE   = 12'h004;
	localparam logic [ADDR_W-1:0] GPIO1_BASE   = 12'h014;
	localparam logic [ADDR_W-1:0] GPIO1_SIZE   = 12'h004;
	localparam logic [ADDR_W-1:0] INTCTRL_BASE = 12'h018;
	localparam logic [ADDR_W-1:0] INTCTRL_SIZE = 12'h004;

	// Device table entries, indexed by slave_t
	localparam logic [15:0] DEV_ID [SLAVE_COUNT] = '{16'd7, 16'd6, 16'd6, 16'd3};
	localparam logic DEV_USEINTR [SLAVE_COUNT] = '{1'b0, 1'b1, 1'b1, 1'b0};
	localparam logic [ADDR_W-1:0] DEV_MAPSZ [SLAVE_COUNT] = '{
		DEVTBL_SIZE, GPIO0_SIZE, GPIO1_SIZE, INTCTRL_SIZE
	};

	localparam int GP0_COUNT = 16;
	localparam int GP1_COUNT = 5;

	// Interrupt controller sources
	localparam int INT_SRC_GP0   = 0;
	localparam int INT_SRC_GP1   = 1;
	localparam int INT_SRC_COUNT = 2;
	localparam logic [DATA_W-1:0] INT_NONE = '1;

	// Peripheral reset stretch
	localparam int RESET_HOLD_CYCLES = 16;
	localparam int RESET_CNT_W = $clog2(RESET_HOLD_CYCLES + 1);
	localparam logic [RESET_CNT_W-1:0] RESET_LOAD = RESET_CNT_W'(RESET_HOLD_CYCLES);

endpackage
